// ==== src.f ====
gb_pkg.sv
gb_bus_if.sv
gb_bus_decode.sv
gb_irq_ctrl.sv
gb_joypad.sv
gb_wram.sv
gb_sys.sv
gb_sys_chk.sv
tb_gb_sys.sv

// ==== tb_gb_sys.sv ====
// testbench for the system bus core with a bus-access table and cartridge and boot rom models
`timescale 1ns/1ps
`default_nettype none

module tb_gb_sys;
	import gb_pkg::*;

	typedef struct {
		bit    rd;   // 1 read, 0 write
		addr_t addr;
		data_t wdata;
		data_t exp;
		bit    gbc;  // colour mode for this access
	} step_t;

	logic clk_cpu, reset_r, is_gbc, fast_boot, cpu_rd, cpu_wr, irq_ack;
	addr_t cpu_addr, cart_addr;
	data_t cpu_do, cart_do, boot_do, cpu_di, irq_vec, cart_di;
	logic [3:0] irq_ext;
	joy_t joy_din;
	logic irq, cart_rd, cart_wr, boot_rom_active;
	logic [1:0] joy_p54;
	logic [7:0] boot_addr;
	step_t steps[$];
	bit boot_on = 1'b1; // expected overlay state
	data_t got;
	int n;

	gb_sys gb_sys_i (.*);

	always #50 clk_cpu = ~clk_cpu;

	// external rom models
	assign cart_do = cart_addr[7:0] ^ 8'ha5;
	assign boot_do = boot_addr ^ 8'h3c;

	function automatic bit is_cart(addr_t a);
		return !a[15] || (a[15:13] == 3'b101); // rom or cart ram
	endfunction

	// ------------------------------------------------------------
	// reporting and typed compares
	// ------------------------------------------------------------

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "first error ends the run");
	endtask

	task automatic check_data(input string what, input data_t g, input data_t e);
		if (g !== e)
			stop_on_error($sformatf("** Error at %0t: %s got %h expected %h", $time, what, g, e));
	endtask

	task automatic check_addr(input string what, input addr_t g, input addr_t e);
		if (g !== e)
			stop_on_error($sformatf("** Error at %0t: %s got %h expected %h", $time, what, g, e));
	endtask

	task automatic check_mask(input string what, input irq_mask_t g, input irq_mask_t e);
		if (g !== e)
			stop_on_error($sformatf("** Error at %0t: %s got %b expected %b", $time, what, g, e));
	endtask

	task automatic check_bit(input string what, input logic g, input logic e);
		if (g !== e)
			stop_on_error($sformatf("** Error at %0t: %s got %b expected %b", $time, what, g, e));
	endtask

	// ------------------------------------------------------------
	// bus accesses
	// ------------------------------------------------------------

	task automatic bus_write(input addr_t a, input data_t d, input bit gbc);
		@(posedge clk_cpu);
		cpu_addr <= a;
		cpu_do   <= d;
		cpu_wr   <= 1'b1;
		is_gbc   <= gbc;
		@(negedge clk_cpu);
		check_bit("cart_wr", cart_wr, is_cart(a));
		check_addr("cart_addr", cart_addr, a);
		check_data("cart_di", cart_di, d);
		@(posedge clk_cpu); // write edge
		cpu_wr <= 1'b0;
	endtask

	task automatic bus_read(input addr_t a, input bit gbc, output data_t d);
		@(posedge clk_cpu);
		cpu_addr <= a;
		cpu_rd   <= 1'b1;
		is_gbc   <= gbc;
		@(negedge clk_cpu);
		check_bit("cart_rd", cart_rd, is_cart(a) && !(boot_on && a < 16'h0100));
		check_bit("boot_rom_active", boot_rom_active, boot_on);
		check_addr("cart_addr", cart_addr, a);
		check_data("boot_addr", boot_addr, a[7:0]);
		@(posedge clk_cpu); // sample edge
		cpu_rd <= 1'b0;
		@(negedge clk_cpu);
		d = cpu_di;         // held from one cycle after the sample
	endtask

	task automatic add_step(input bit rd, input addr_t a, input data_t wd, input data_t e,
			input bit gbc);
		step_t s;
		s.rd    = rd;
		s.addr  = a;
		s.wdata = wd;
		s.exp   = e;
		s.gbc   = gbc;
		steps.push_back(s);
	endtask

	task automatic build_table();
		addr_t a;
		data_t d;
		addr_t boot_pts[3] = '{16'h0000, 16'h0042, 16'h00ff};
		// boot overlay, fast boot flag, then cartridge
		foreach (boot_pts[i])
			add_step(1, boot_pts[i], 0, boot_pts[i][7:0] ^ 8'h3c, 0);
		add_step(1, REG_BOOT, 0, 8'h42, 0);
		add_step(0, REG_BOOT, 8'h01, 0, 0);
		add_step(1, 16'h0000, 0, 8'ha5, 0);
		add_step(1, 16'h0042, 0, 8'h42 ^ 8'ha5, 0);
		add_step(1, REG_BOOT, 0, 8'hff, 0);  // flag gone with the overlay
		add_step(1, 16'ha000, 0, 8'ha5, 0);
		add_step(1, 16'hbf7e, 0, 8'h7e ^ 8'ha5, 0);
		// wram, echo both ways, hram
		for (int i = 0; i < 6; i++) begin
			a = 16'hc000 | addr_t'($urandom & 16'h0fff);
			d = data_t'($urandom);
			add_step(0, a, d, 0, 0);
			add_step(1, a, 0, d, 0);
			add_step(1, a + 16'h2000, 0, d, 0);
			a = 16'hf000 | addr_t'($urandom % 16'h0e00); // echo of d000 bank
			d = data_t'($urandom);
			add_step(0, a, d, 0, 0);
			add_step(1, a - 16'h2000, 0, d, 0);
			a = 16'hff80 + addr_t'($urandom % 127);
			d = data_t'($urandom);
			add_step(0, a, d, 0, 0);
			add_step(1, a, 0, d, 0);
		end
		add_step(1, 16'hff03, 0, 8'hff, 0);  // unmapped io
		// svbk banks in colour mode
		for (int k = 1; k < 8; k++) begin
			add_step(0, REG_SVBK, data_t'(k), 0, 1);
			add_step(0, 16'hd000, 8'h30 + data_t'(k), 0, 1);
		end
		for (int k = 7; k > 0; k--) begin
			add_step(0, REG_SVBK, data_t'(k), 0, 1);
			add_step(1, REG_SVBK, 0, 8'hf8 | data_t'(k), 1);
			add_step(1, 16'hd000, 0, 8'h30 + data_t'(k), 1);
		end
		add_step(0, REG_SVBK, 8'h00, 0, 1);
		add_step(1, REG_SVBK, 0, 8'hf9, 1);  // 0 turns into bank 1
		add_step(1, 16'hd000, 0, 8'h31, 1);
		add_step(0, REG_SVBK, 8'h03, 0, 1);  // colour bank 3 left behind
		add_step(0, REG_SVBK, 8'h05, 0, 0);  // ignored in mono
		add_step(1, 16'hd000, 0, 8'h31, 0);  // mono still sees bank 1
		add_step(1, REG_SVBK, 0, 8'hf9, 0);
		add_step(1, REG_SVBK, 0, 8'hfb, 1);  // bank 3 survived the mono write
	endtask

	task automatic ack_pulse();
		@(posedge clk_cpu);
		irq_ack <= 1'b1;
		@(posedge clk_cpu);
		irq_ack <= 1'b0;
		@(posedge clk_cpu); // clear edge
		@(negedge clk_cpu);
	endtask

	// ------------------------------------------------------------
	// run
	// ------------------------------------------------------------

	initial begin
		repeat (40000) @(posedge clk_cpu);
		stop_on_error("run did not finish within the cycle limit");
	end

	initial begin
		clk_cpu   = 0;
		reset_r   = 1;
		is_gbc    = 0;
		fast_boot = 1;
		cpu_rd    = 0;
		cpu_wr    = 0;
		irq_ack   = 0;
		cpu_addr  = '0;
		cpu_do    = '0;
		irq_ext   = '0;
		joy_din   = 4'hf;
		void'($urandom(32'h2bb2_bc0b));
		build_table();
		repeat (16) @(posedge clk_cpu);
		reset_r <= 1'b0;

		foreach (steps[i]) begin
			if (steps[i].rd) begin
				bus_read(steps[i].addr, steps[i].gbc, got);
				check_data($sformatf("read %h", steps[i].addr), got, steps[i].exp);
			end else begin
				bus_write(steps[i].addr, steps[i].wdata, steps[i].gbc);
				if (steps[i].addr == REG_BOOT && (steps[i].gbc ?
						steps[i].wdata == BOOT_OFF_GBC : steps[i].wdata[0]))
					boot_on = 1'b0;
			end
		end

		// timer and lcdc requests where lcdc wins
		bus_write(REG_IE, 8'h1f, 0);
		bus_read(REG_IE, 0, got);
		check_data("IE", got, 8'h1f);
		@(posedge clk_cpu);
		irq_ext <= 4'b0110;
		@(posedge clk_cpu);
		irq_ext <= 4'b0000;
		n = 0;
		while (!irq && n < 20) begin
			@(negedge clk_cpu);
			n++;
		end
		if (!irq)
			stop_on_error("irq never rose after the timer and lcdc requests");
		bus_read(REG_IF, 0, got);
		check_mask("IF pending", got[NUM_IRQ-1:0], 5'b00110);
		check_data("irq_vec lcdc", irq_vec, 8'h48);
		ack_pulse();
		check_data("irq_vec timer", irq_vec, 8'h50);
		ack_pulse();
		check_data("irq_vec none", irq_vec, 8'h55);
		check_bit("irq after acks", irq, 1'b0);
		bus_read(REG_IF, 0, got);
		check_data("IF cleared", got, 8'he0);

		// joypad with its interrupt masked
		bus_write(REG_IE, 8'hef, 0);
		bus_read(REG_IE, 0, got);
		check_data("IE top bits", got, 8'h0f);
		bus_write(REG_P1, 8'h10, 0);
		@(negedge clk_cpu);
		check_bit("joy_p54[1]", joy_p54[1], 1'b0);
		check_bit("joy_p54[0]", joy_p54[0], 1'b1);
		bus_read(REG_P1, 0, got);
		check_data("P1", got, 8'hc0 | 8'h10 | {4'h0, joy_din});
		@(posedge clk_cpu);
		joy_din <= 4'hb; // line 2 pressed
		n = 0;
		got = '0;
		while (!got[4] && n < 10) begin
			bus_read(REG_IF, 0, got);
			n++;
		end
		if (!got[4])
			stop_on_error("IF bit 4 never set after the joypad line fell");
		check_mask("IF joypad", got[NUM_IRQ-1:0], 5'b10000);
		check_bit("irq masked", irq, 1'b0);
		bus_read(REG_P1, 0, got);
		check_data("P1 pressed", got, 8'hdb);

		$display("test passed");
		$finish;
	end

endmodule : tb_gb_sys

`default_nettype wire

// ==== gb_sys_chk.sv ====
// bound assertions for cartridge strobes, the interrupt line and the reset read value
`timescale 1ns/1ps
`default_nettype none

module gb_sys_chk (
	input logic          clk_cpu,
	input logic          reset_r,
	input logic          cpu_wr,
	input logic          cart_rd,
	input logic          cart_wr,
	input logic          irq,
	input gb_pkg::data_t if_rdata,
	input gb_pkg::data_t ie_rdata,
	input gb_pkg::data_t cpu_di
);
	import gb_pkg::*;

	// ------------------------------------------------------------
	// cartridge strobes
	// ------------------------------------------------------------

	a_cart_excl: assert property (@(posedge clk_cpu) disable iff (reset_r)
		!(cart_rd && cart_wr)) else $error("cart_rd and cart_wr high together");

	a_cart_wr_src: assert property (@(posedge clk_cpu) disable iff (reset_r)
		cart_wr |-> cpu_wr) else $error("cart_wr without a cpu write");

	// ------------------------------------------------------------
	// interrupt line and read data after reset
	// ------------------------------------------------------------

	a_irq_line: assert property (@(posedge clk_cpu) disable iff (reset_r)
		irq == |(if_rdata[NUM_IRQ-1:0] & ie_rdata[NUM_IRQ-1:0]))
		else $error("irq does not match IE and IF");

	// first edge out of reset still shows the reset value
	a_reset_di: assert property (@(posedge clk_cpu)
		$fell(reset_r) |-> cpu_di == OPEN_BUS) else $error("cpu_di not FFh after reset");

endmodule : gb_sys_chk

bind gb_sys gb_sys_chk gb_sys_chk_i (
	.clk_cpu  (clk_cpu),
	.reset_r  (reset_r),
	.cpu_wr   (cpu_wr),
	.cart_rd  (cart_rd),
	.cart_wr  (cart_wr),
	.irq      (irq),
	.if_rdata (if_rdata),
	.ie_rdata (ie_rdata),
	.cpu_di   (cpu_di)
);

`default_nettype wire

// ==== gb_sys.sv ====
// system bus top level joining decoder, interrupt controller, joypad and work ram
`timescale 1ns/1ps
`default_nettype none

module gb_sys (
	input  logic          clk_cpu,
	input  logic          reset_r,
	input  logic          is_gbc,
	input  logic          fast_boot,
	input  gb_pkg::addr_t cpu_addr,
	input  gb_pkg::data_t cpu_do,
	input  logic          cpu_rd,
	input  logic          cpu_wr,
	input  logic          irq_ack,
	input  logic [3:0]    irq_ext,   // vblank, lcdc, timer, serial
	input  gb_pkg::joy_t  joy_din,
	input  gb_pkg::data_t cart_do,
	input  gb_pkg::data_t boot_do,
	output gb_pkg::data_t cpu_di,
	output logic          irq,
	output gb_pkg::data_t irq_vec,
	output logic [1:0]    joy_p54,
	output gb_pkg::addr_t cart_addr,
	output gb_pkg::data_t cart_di,
	output logic          cart_rd,
	output logic          cart_wr,
	output logic [7:0]    boot_addr,
	output logic          boot_rom_active
);
	import gb_pkg::*;

	gb_bus_if bus ();

	// read data back to the decoder
	data_t p1_rdata;
	data_t if_rdata;
	data_t ie_rdata;
	data_t svbk_rdata;
	data_t ram_rdata;
	logic  joy_irq;

	// ------------------------------------------------------------
	// decode and read mux
	// ------------------------------------------------------------

	gb_bus_decode decode_i (
		.clk_cpu         (clk_cpu),
		.reset_r         (reset_r),
		.is_gbc          (is_gbc),
		.fast_boot       (fast_boot),
		.cpu_addr        (cpu_addr),
		.cpu_do          (cpu_do),
		.cpu_rd          (cpu_rd),
		.cpu_wr          (cpu_wr),
		.bus             (bus.decoder),
		.p1_rdata        (p1_rdata),
		.if_rdata        (if_rdata),
		.ie_rdata        (ie_rdata),
		.svbk_rdata      (svbk_rdata),
		.ram_rdata       (ram_rdata),
		.cart_do         (cart_do),
		.boot_do         (boot_do),
		.cpu_di          (cpu_di),
		.cart_addr       (cart_addr),
		.cart_di         (cart_di),
		.cart_rd         (cart_rd),
		.cart_wr         (cart_wr),
		.boot_addr       (boot_addr),
		.boot_rom_active (boot_rom_active)
	);

	// ------------------------------------------------------------
	// targets
	// ------------------------------------------------------------

	gb_irq_ctrl irq_ctrl_i (
		.clk_cpu  (clk_cpu),
		.reset_r  (reset_r),
		.bus      (bus.target),
		.irq_ext  (irq_ext),
		.joy_irq  (joy_irq),
		.irq_ack  (irq_ack),
		.if_rdata (if_rdata),
		.ie_rdata (ie_rdata),
		.irq      (irq),
		.irq_vec  (irq_vec)
	);

	gb_joypad joypad_i (
		.clk_cpu  (clk_cpu),
		.reset_r  (reset_r),
		.bus      (bus.target),
		.joy_din  (joy_din),
		.p1_rdata (p1_rdata),
		.joy_p54  (joy_p54),
		.joy_irq  (joy_irq)   // feeds if bit 4
	);

	gb_wram wram_i (
		.clk_cpu    (clk_cpu),
		.reset_r    (reset_r),
		.is_gbc     (is_gbc),
		.bus        (bus.target),
		.ram_rdata  (ram_rdata),
		.svbk_rdata (svbk_rdata)
	);

endmodule : gb_sys

`default_nettype wire

// ==== gb_wram.sv ====
// banked work ram with echo, high ram, and the svbk bank register
`timescale 1ns/1ps
`default_nettype none

module gb_wram (
	input  logic          clk_cpu,
	input  logic          reset_r,
	input  logic          is_gbc,
	gb_bus_if.target      bus,
	output gb_pkg::data_t ram_rdata,
	output gb_pkg::data_t svbk_rdata
);
	import gb_pkg::*;

	data_t      wram_mem [2**$bits(wram_addr_t)]; // 32k, 8 banks
	data_t      hram_mem [127];                   // ff80..fffe
	wram_bank_t bank_r;
	wram_bank_t bank_eff;
	wram_addr_t wram_addr;
	hram_addr_t hram_addr;
	data_t      wram_q;
	data_t      hram_q;
	logic       hram_sel_q; // last ram read was hram

	// ------------------------------------------------------------
	// svbk
	// ------------------------------------------------------------

	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			bank_r <= wram_bank_t'(1);
		end else if (bus.sel_svbk && bus.wr && is_gbc) begin
			if (bus.wdata[2:0] == 3'd0)
				bank_r <= wram_bank_t'(1); // bank 0 not selectable here
			else
				bank_r <= bus.wdata[2:0];
		end
	end

	assign bank_eff   = is_gbc ? bank_r : wram_bank_t'(1); // mono fixed at 1
	assign svbk_rdata = {5'b11111, bank_eff};

	// ------------------------------------------------------------
	// address mapping
	// ------------------------------------------------------------

	// a12 low is bank 0, high is the switched bank; echo aliases via a12..a0
	assign wram_addr = bus.addr[12] ? {bank_eff, bus.addr[11:0]} : {3'd0, bus.addr[11:0]};
	assign hram_addr = bus.addr[6:0];

	// ------------------------------------------------------------
	// rams
	// ------------------------------------------------------------

	always_ff @(posedge clk_cpu) begin
		if (bus.sel_wram && bus.wr)
			wram_mem[wram_addr] <= bus.wdata;
		if (bus.sel_wram && bus.rd)
			wram_q <= wram_mem[wram_addr];
	end

	always_ff @(posedge clk_cpu) begin
		if (bus.sel_hram && bus.wr)
			hram_mem[hram_addr] <= bus.wdata;
		if (bus.sel_hram && bus.rd)
			hram_q <= hram_mem[hram_addr];
	end

	always_ff @(posedge clk_cpu) begin
		if (reset_r)
			hram_sel_q <= 1'b0;
		else if (bus.rd && (bus.sel_wram || bus.sel_hram))
			hram_sel_q <= bus.sel_hram;
	end

	assign ram_rdata = hram_sel_q ? hram_q : wram_q; // both hold between reads

endmodule : gb_wram

`default_nettype wire

// ==== gb_joypad.sv ====
// joypad p1 select register, input line synchroniser and falling edge interrupt
`timescale 1ns/1ps
`default_nettype none

module gb_joypad (
	input  logic          clk_cpu,
	input  logic          reset_r,
	gb_bus_if.target      bus,
	input  gb_pkg::joy_t  joy_din,
	output gb_pkg::data_t p1_rdata,
	output logic [1:0]    joy_p54,
	output logic          joy_irq
);
	import gb_pkg::*;

	logic [1:0] p54_r;  // row select, active low
	joy_t       joy_s1; // sync stage 1
	joy_t       joy_s2; // sync stage 2
	joy_t       joy_old;

	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			p54_r   <= 2'b11;   // no row selected
			joy_s1  <= '1;      // lines idle high
			joy_s2  <= '1;
			joy_old <= '1;
			joy_irq <= 1'b0;
		end else begin
			if (bus.sel_p1 && bus.wr)
				p54_r <= bus.wdata[5:4];
			joy_s1  <= joy_din;
			joy_s2  <= joy_s1;
			joy_old <= joy_s2;
			joy_irq <= |(joy_old & ~joy_s2); // any line went low
		end
	end

	assign joy_p54  = p54_r;
	assign p1_rdata = {2'b11, p54_r, joy_din}; // lines read live

endmodule : gb_joypad

`default_nettype wire

// ==== gb_irq_ctrl.sv ====
// interrupt flag and enable registers, request edge capture, priority vector and acknowledge
`timescale 1ns/1ps
`default_nettype none

module gb_irq_ctrl (
	input  logic          clk_cpu,
	input  logic          reset_r,
	gb_bus_if.target      bus,
	input  logic [3:0]    irq_ext,   // vblank, lcdc, timer, serial
	input  logic          joy_irq,   // already a one cycle pulse
	input  logic          irq_ack,
	output gb_pkg::data_t if_rdata,
	output gb_pkg::data_t ie_rdata,
	output logic          irq,
	output gb_pkg::data_t irq_vec
);
	import gb_pkg::*;

	irq_mask_t  if_r;
	irq_mask_t  ie_r;
	irq_mask_t  if_next;
	irq_mask_t  pending;  // flagged and enabled
	irq_mask_t  ack_clr;  // lowest pending bit
	logic [3:0] req_s;    // sampled request lines
	logic [3:0] req_d;    // previous sample
	logic [3:0] req_rise_q;
	logic       ack_q;

	// ------------------------------------------------------------
	// request edges
	// ------------------------------------------------------------

	// rise seen between sample and delay, then one more stage into if
	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			req_s      <= '0;
			req_d      <= '0;
			req_rise_q <= '0;
			ack_q      <= 1'b0;
		end else begin
			req_s      <= irq_ext;
			req_d      <= req_s;
			req_rise_q <= req_s & ~req_d;
			ack_q      <= irq_ack;
		end
	end

	// ------------------------------------------------------------
	// flag and enable registers
	// ------------------------------------------------------------

	assign pending = if_r & ie_r;
	assign ack_clr = pending & (~pending + irq_mask_t'(1)); // isolate lowest set bit

	always_comb begin
		if_next = if_r | {joy_irq, req_rise_q};
		if (ack_q && !irq_ack)
			if_next = if_next & ~ack_clr; // ack just ended
		if (bus.sel_if && bus.wr)
			if_next = irq_mask_t'(bus.wdata[NUM_IRQ-1:0]); // cpu write wins
	end

	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			if_r <= '0;
			ie_r <= '0;
		end else begin
			if_r <= if_next;
			if (bus.sel_ie && bus.wr)
				ie_r <= irq_mask_t'(bus.wdata[NUM_IRQ-1:0]);
		end
	end

	assign if_rdata = {3'b111, if_r}; // unused bits read high
	assign ie_rdata = {3'b000, ie_r};

	// ------------------------------------------------------------
	// cpu side
	// ------------------------------------------------------------

	assign irq = |pending;

	// walk down so the lowest index is left last
	always_comb begin
		irq_vec = IRQ_VEC_NONE;
		for (int i = NUM_IRQ - 1; i >= 0; i--) begin
			if (pending[i])
				irq_vec = data_t'(IRQ_VEC_BASE + IRQ_VEC_STEP * i);
		end
	end

endmodule : gb_irq_ctrl

`default_nettype wire

// ==== gb_bus_decode.sv ====
// address map decode, boot rom overlay control, cartridge bus and registered read mux
`timescale 1ns/1ps
`default_nettype none

module gb_bus_decode (
	input  logic           clk_cpu,
	input  logic           reset_r,
	input  logic           is_gbc,
	input  logic           fast_boot,
	input  gb_pkg::addr_t  cpu_addr,
	input  gb_pkg::data_t  cpu_do,
	input  logic           cpu_rd,
	input  logic           cpu_wr,
	gb_bus_if.decoder      bus,
	input  gb_pkg::data_t  p1_rdata,
	input  gb_pkg::data_t  if_rdata,
	input  gb_pkg::data_t  ie_rdata,
	input  gb_pkg::data_t  svbk_rdata,
	input  gb_pkg::data_t  ram_rdata,
	input  gb_pkg::data_t  cart_do,
	input  gb_pkg::data_t  boot_do,
	output gb_pkg::data_t  cpu_di,
	output gb_pkg::addr_t  cart_addr,
	output gb_pkg::data_t  cart_di,
	output logic           cart_rd,
	output logic           cart_wr,
	output logic [7:0]     boot_addr,
	output logic           boot_rom_active
);
	import gb_pkg::*;

	logic  sel_cart;   // rom 0000..7fff or cart ram a000..bfff
	logic  sel_boot;   // ff50
	logic  boot_hit;   // overlay answers this read
	logic  sel_ram;    // data comes from a sync ram next cycle
	logic  boot_en_r;
	data_t rd_mux;     // combinational sources at the read edge
	data_t rdata_q;
	logic  src_ram_q;

	// ------------------------------------------------------------
	// region decode
	// ------------------------------------------------------------

	assign sel_cart = ~cpu_addr[15] || (cpu_addr[15:13] == 3'b101);
	assign sel_boot = (cpu_addr == REG_BOOT);
	assign boot_hit = boot_en_r && (cpu_addr[15:8] == 8'h00);

	assign bus.addr     = cpu_addr;
	assign bus.wdata    = cpu_do;
	assign bus.wr       = cpu_wr;
	assign bus.rd       = cpu_rd;
	assign bus.sel_p1   = (cpu_addr == REG_P1);
	assign bus.sel_if   = (cpu_addr == REG_IF);
	assign bus.sel_ie   = (cpu_addr == REG_IE);
	assign bus.sel_svbk = (cpu_addr == REG_SVBK);
	// c000..fdff, the fe page and up excluded
	assign bus.sel_wram = (cpu_addr[15:14] == 2'b11) && ~&cpu_addr[13:9];
	assign bus.sel_hram = (cpu_addr[15:7] == 9'h1ff) && (cpu_addr != REG_IE);

	assign sel_ram = bus.sel_wram || bus.sel_hram;

	// ------------------------------------------------------------
	// cartridge and boot rom pins
	// ------------------------------------------------------------

	assign cart_addr = cpu_addr;
	assign cart_di   = cpu_do;
	assign cart_rd   = cpu_rd && sel_cart && !boot_hit; // overlay hides the cart
	assign cart_wr   = cpu_wr && sel_cart;   // mbc writes go through always
	assign boot_addr = cpu_addr[7:0];
	assign boot_rom_active = boot_en_r;

	// mono exits on bit 0, colour needs the full 11h
	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			boot_en_r <= 1'b1;
		end else if (cpu_wr && sel_boot) begin
			if (is_gbc ? (cpu_do == BOOT_OFF_GBC) : cpu_do[0])
				boot_en_r <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------

	always_comb begin
		if (boot_hit)
			rd_mux = boot_do;
		else if (sel_cart)
			rd_mux = cart_do;
		else if (bus.sel_p1)
			rd_mux = p1_rdata;
		else if (bus.sel_if)
			rd_mux = if_rdata;
		else if (bus.sel_ie)
			rd_mux = ie_rdata;
		else if (bus.sel_svbk)
			rd_mux = svbk_rdata;
		else if (sel_boot && fast_boot && boot_en_r)
			rd_mux = FAST_BOOT_FLAG; // boot code skips the logo
		else
			rd_mux = OPEN_BUS;       // unmapped io reads ff
	end

	// sample at the read edge, hold until the next read
	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			rdata_q   <= OPEN_BUS;
			src_ram_q <= 1'b0;
		end else if (cpu_rd) begin
			rdata_q   <= rd_mux;
			src_ram_q <= sel_ram;
		end
	end

	assign cpu_di = src_ram_q ? ram_rdata : rdata_q; // ram output already registered

endmodule : gb_bus_decode

`default_nettype wire

// ==== gb_bus_if.sv ====
// decoded cpu access, carried from the address decoder to the register and ram blocks
`timescale 1ns/1ps
`default_nettype none

interface gb_bus_if;
	import gb_pkg::*;

	addr_t addr;  // raw cpu address, ram blocks use the low bits
	data_t wdata; // cpu write data
	logic wr;
	logic rd;

	// one-hot region selects
	logic sel_p1;
	logic sel_if;
	logic sel_ie;
	logic sel_svbk;
	logic sel_wram; // c000..fdfx incl. echo
	logic sel_hram; // ff80..fffe

	modport decoder (
		output addr, wdata, wr, rd,
		output sel_p1, sel_if, sel_ie, sel_svbk, sel_wram, sel_hram
	);

	modport target (
		input addr, wdata, wr, rd,
		input sel_p1, sel_if, sel_ie, sel_svbk, sel_wram, sel_hram
	);

endinterface : gb_bus_if

`default_nettype wire

// ==== gb_pkg.sv ====
// shared bus types, register addresses and interrupt constants for the system bus core
`default_nettype none

package gb_pkg;

	// ------------------------------------------------------------
	// widths with a meaning
	// ------------------------------------------------------------

	localparam int NUM_IRQ = 5; // vblank, lcdc, timer, serial, joypad

	typedef logic [15:0] addr_t;          // cpu address
	typedef logic [7:0]  data_t;          // one bus byte
	typedef logic [NUM_IRQ-1:0] irq_mask_t; // bit 0 vblank .. bit 4 joypad
	typedef logic [14:0] wram_addr_t;     // physical wram, 8 banks of 4k
	typedef logic [2:0]  wram_bank_t;     // svbk bank number
	typedef logic [6:0]  hram_addr_t;     // ff80..fffe offset
	typedef logic [3:0]  joy_t;           // p10..p13 lines

	// ------------------------------------------------------------
	// io register addresses
	// ------------------------------------------------------------

	localparam addr_t REG_P1   = 16'hff00; // joypad select / lines
	localparam addr_t REG_IF   = 16'hff0f; // interrupt flags
	localparam addr_t REG_BOOT = 16'hff50; // boot rom disable
	localparam addr_t REG_SVBK = 16'hff70; // wram bank, colour only
	localparam addr_t REG_IE   = 16'hffff; // interrupt enable

	// ------------------------------------------------------------
	// interrupt vectors
	// ------------------------------------------------------------

	// source n jumps to base + step * n
	localparam data_t IRQ_VEC_BASE = 8'h40;
	localparam int unsigned IRQ_VEC_STEP = 8;
	localparam data_t IRQ_VEC_NONE = 8'h55; // nothing pending

	// ------------------------------------------------------------
	// misc bus values
	// ------------------------------------------------------------

	localparam data_t FAST_BOOT_FLAG = 8'h42; // seen by boot code at ff50
	localparam data_t OPEN_BUS       = 8'hff; // nothing drives the bus
	localparam data_t BOOT_OFF_GBC   = 8'h11; // colour boot rom exit value

endpackage : gb_pkg

`default_nettype wire
